// ==== hw/id_settings.svh ====
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// Datapath width
`define XLEN 32

// Register file address width, 32 registers
`define REG_AW 5

// M extension, MUL through REMU
`define HAS_MULDIV 1

`endif

// ==== hw/id_pkg.sv ====
`default_nettype none

`include "id_settings.svh"

package id_pkg;

  typedef logic [`XLEN-1:0]   xlen_t;
  typedef logic [31:0]        instr_t;
  typedef logic [`REG_AW-1:0] reg_addr_t;

  //////////////////////////////////////////////////
  // Major opcodes, instr[6:2]
  //////////////////////////////////////////////////
  typedef enum logic [4:0] {
    OPC_LOAD     = 5'b00000,
    OPC_MISC_MEM = 5'b00011,
    OPC_OP_IMM   = 5'b00100,
    OPC_AUIPC    = 5'b00101,
    OPC_STORE    = 5'b01000,
    OPC_OP       = 5'b01100,
    OPC_LUI      = 5'b01101,
    OPC_BRANCH   = 5'b11000,
    OPC_JALR     = 5'b11001,
    OPC_JAL      = 5'b11011,
    OPC_SYSTEM   = 5'b11100
  } opcode_e;

  // Operand A source
  typedef enum logic [1:0] {
    OPA_REG  = 2'd0,
    OPA_PC   = 2'd1,
    OPA_ZERO = 2'd2
  } op_a_sel_e;

  // Operand B source
  typedef enum logic [1:0] {
    OPB_REG  = 2'd0,
    OPB_IMM  = 2'd1,
    OPB_ZIMM = 2'd2  // rs1 field as unsigned imm, CSRxxI
  } op_b_sel_e;

endpackage

`default_nettype wire

// ==== hw/dec_if.sv ====
`default_nettype none

interface dec_if import id_pkg::*; ();

  opcode_e   opcode;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  logic      uses_rs1;   // Already false for x0
  logic      uses_rs2;
  logic      writes_rd;  // Already false for x0
  op_a_sel_e op_a_sel;
  op_b_sel_e op_b_sel;
  xlen_t     imm;

  modport producer (output opcode, rs1, rs2, rd, uses_rs1, uses_rs2, writes_rd,
                    output op_a_sel, op_b_sel, imm);
  modport consumer (input  opcode, rs1, rs2, rd, uses_rs1, uses_rs2, writes_rd,
                    input  op_a_sel, op_b_sel, imm);

endinterface

`default_nettype wire

// ==== hw/instr_decoder.sv ====
`default_nettype none

module instr_decoder import id_pkg::*; (
  input  instr_t    instr,
  dec_if.producer   dec,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr
);

  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_u;
  xlen_t imm_j;
  logic  use_a;
  logic  use_b;
  logic  wr;

  assign dec.opcode = opcode_e'(instr[6:2]);
  assign dec.rs1    = instr[19:15];
  assign dec.rs2    = instr[24:20];
  assign dec.rd     = instr[11:7];

  assign rs1_addr = dec.rs1;  // Register file reads in this cycle
  assign rs2_addr = dec.rs2;

  //////////////////////////////////////////////////
  // Immediates, all sign extended from instr[31]
  //////////////////////////////////////////////////
  assign imm_i = xlen_t'($signed(instr[31:20]));
  assign imm_s = xlen_t'($signed({instr[31:25], instr[11:7]}));
  assign imm_b = xlen_t'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
  assign imm_u = xlen_t'($signed({instr[31:12], 12'b0}));
  assign imm_j = xlen_t'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}));

  // Format, operand sources and register usage per opcode
  always_comb begin
    use_a        = 1'b1;
    use_b        = 1'b0;
    wr           = 1'b1;
    dec.op_a_sel = OPA_REG;
    dec.op_b_sel = OPB_IMM;
    dec.imm      = imm_i;  // I-type unless overridden
    case (dec.opcode)
      OPC_LOAD, OPC_OP_IMM, OPC_JALR: ;
      OPC_OP: begin
        use_b        = 1'b1;
        dec.op_b_sel = OPB_REG;
      end
      OPC_BRANCH: begin
        use_b        = 1'b1;
        wr           = 1'b0;
        dec.op_b_sel = OPB_REG;
        dec.imm      = imm_b;  // Target offset goes on id_imm
      end
      OPC_STORE: begin
        use_b        = 1'b1;
        wr           = 1'b0;
        dec.op_b_sel = OPB_REG;  // Store data
        dec.imm      = imm_s;
      end
      OPC_LUI: begin
        use_a        = 1'b0;
        dec.op_a_sel = OPA_ZERO;
        dec.imm      = imm_u;
      end
      OPC_AUIPC: begin
        use_a        = 1'b0;
        dec.op_a_sel = OPA_PC;
        dec.imm      = imm_u;
      end
      OPC_JAL: begin
        use_a        = 1'b0;
        dec.op_a_sel = OPA_PC;
        dec.imm      = imm_j;
      end
      OPC_SYSTEM: dec.op_b_sel = OPB_ZIMM;
      default: begin  // FENCE and unknown opcodes
        use_a = 1'b0;
        wr    = 1'b0;
      end
    endcase
  end

  // x0 never creates a dependency
  assign dec.uses_rs1  = use_a & (|dec.rs1);
  assign dec.uses_rs2  = use_b & (|dec.rs2);
  assign dec.writes_rd = wr & (|dec.rd);

endmodule

`default_nettype wire

// ==== hw/illegal_check.sv ====
`default_nettype none

`include "id_settings.svh"

module illegal_check import id_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  instr_t instr,
  input  logic   hold,
  output logic   id_illegal
);

  localparam bit has_muldiv = (`HAS_MULDIV != 0);

  logic [6:0] funct7;
  logic [2:0] funct3;
  opcode_e    opcode;
  logic       illegal;

  assign funct7 = instr[31:25];
  assign funct3 = instr[14:12];
  assign opcode = opcode_e'(instr[6:2]);

  always_comb begin
    illegal = 1'b1;  // Anything not listed below
    case (opcode)
      OPC_LUI, OPC_AUIPC, OPC_JAL: illegal = 1'b0;
      OPC_JALR:     illegal = (funct3 != 3'b000);
      OPC_BRANCH:   illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
      OPC_LOAD:     illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      OPC_STORE:    illegal = (funct3 > 3'b010);
      OPC_MISC_MEM: illegal = (funct3[2:1] != 2'b00);  // FENCE, FENCE.I
      OPC_OP_IMM: begin
        case (funct3)
          3'b001:  illegal = (funct7 != 7'b0000000);  // SLLI, shamt[5] set too
          3'b101:  illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          default: illegal = 1'b0;
        endcase
      end
      OPC_OP: begin
        case (funct7)
          7'b0000000: illegal = 1'b0;
          7'b0100000: illegal = (funct3 != 3'b000) && (funct3 != 3'b101);  // SUB, SRA
          7'b0000001: illegal = !has_muldiv;  // MUL .. REMU
          default:    illegal = 1'b1;
        endcase
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b000)  // Only ECALL and EBREAK
          illegal = (instr[31:21] != 11'd0) || (instr[19:7] != 13'd0);
        else
          illegal = (funct3 == 3'b100);  // CSR forms by encoding only
      end
      default: illegal = 1'b1;
    endcase
    if (instr[1:0] != 2'b11)  // No compressed support
      illegal = 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      id_illegal <= 1'b0;
    else if (!hold)
      id_illegal <= illegal;
  end

endmodule

`default_nettype wire

// ==== hw/bypass_ctrl.sv ====
`default_nettype none

module bypass_ctrl import id_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      hold,
  dec_if.consumer   dec,
  input  logic      id_valid,
  input  reg_addr_t ex_rd,
  input  logic      ex_wr,
  input  reg_addr_t wb_rd,
  input  logic      wb_wr,
  output reg_addr_t id_rd,
  output logic      id_use_rf_a,
  output logic      id_use_rf_b,
  output logic      id_byp_ex_a,
  output logic      id_byp_ex_b,
  output logic      id_byp_wb_a,
  output logic      id_byp_wb_b
);

  logic id_wr;  // writes_rd of the instruction now on the outputs

  //////////////////////////////////////////////////
  // Forwarding flags, registered with the instr
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_wr       <= 1'b0;
      id_use_rf_a <= 1'b0;
      id_use_rf_b <= 1'b0;
      id_byp_ex_a <= 1'b0;
      id_byp_ex_b <= 1'b0;
      id_byp_wb_a <= 1'b0;
      id_byp_wb_b <= 1'b0;
    end else if (!hold) begin
      id_wr       <= dec.writes_rd;
      // Result still in execute next cycle
      id_byp_ex_a <= dec.uses_rs1 & id_valid & id_wr & (dec.rs1 == id_rd);
      id_byp_ex_b <= dec.uses_rs2 & id_valid & id_wr & (dec.rs2 == id_rd);
      id_byp_wb_a <= dec.uses_rs1 & ex_wr & (dec.rs1 == ex_rd);
      id_byp_wb_b <= dec.uses_rs2 & ex_wr & (dec.rs2 == ex_rd);
      // Register file value is stale while writeback targets it
      id_use_rf_a <= dec.uses_rs1 & ~(wb_wr & (dec.rs1 == wb_rd));
      id_use_rf_b <= dec.uses_rs2 & ~(wb_wr & (dec.rs2 == wb_rd));
    end
  end

  always_ff @(posedge clk) begin
    if (!hold)
      id_rd <= dec.rd;
  end

endmodule

`default_nettype wire

// ==== hw/operand_select.sv ====
`default_nettype none

module operand_select import id_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid,
  input  xlen_t   in_pc,
  input  logic    hold,
  input  logic    flush,
  input  xlen_t   rs1_data,
  input  xlen_t   rs2_data,
  dec_if.consumer dec,
  output logic    id_valid,
  output xlen_t   id_pc,
  output xlen_t   id_op_a,
  output xlen_t   id_op_b,
  output xlen_t   id_imm
);

  xlen_t op_a;
  xlen_t op_b;

  always_comb begin
    case (dec.op_a_sel)
      OPA_PC:   op_a = in_pc;
      OPA_ZERO: op_a = '0;
      default:  op_a = rs1_data;
    endcase
    case (dec.op_b_sel)
      OPB_IMM:  op_b = dec.imm;
      OPB_ZIMM: op_b = xlen_t'(dec.rs1);  // Zero extended
      default:  op_b = rs2_data;
    endcase
  end

  // Flush wins over hold
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      id_valid <= 1'b0;
    else if (flush)
      id_valid <= 1'b0;
    else if (!hold)
      id_valid <= in_valid;
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      id_pc   <= in_pc;
      id_op_a <= op_a;
      id_op_b <= op_b;
      id_imm  <= dec.imm;
    end
  end

endmodule

`default_nettype wire

// ==== hw/id_stage.sv ====
`default_nettype none

module id_stage import id_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  instr_t    in_instr,
  input  xlen_t     in_pc,
  input  logic      hold,
  input  logic      flush,

  // Register file
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  input  xlen_t     rs1_data,
  input  xlen_t     rs2_data,

  // Destinations of later stages
  input  reg_addr_t ex_rd,
  input  logic      ex_wr,
  input  reg_addr_t wb_rd,
  input  logic      wb_wr,

  // To execute
  output logic      id_valid,
  output xlen_t     id_pc,
  output xlen_t     id_op_a,
  output xlen_t     id_op_b,
  output xlen_t     id_imm,
  output reg_addr_t id_rd,
  output logic      id_illegal,
  output logic      id_use_rf_a,
  output logic      id_use_rf_b,
  output logic      id_byp_ex_a,
  output logic      id_byp_ex_b,
  output logic      id_byp_wb_a,
  output logic      id_byp_wb_b
);

  dec_if dec ();

  instr_decoder u_decoder (
    .instr    (in_instr),
    .dec      (dec),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr)
  );

  illegal_check u_illegal (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr      (in_instr),
    .hold       (hold),
    .id_illegal (id_illegal)
  );

  bypass_ctrl u_bypass (
    .clk         (clk),
    .rst_n       (rst_n),
    .hold        (hold),
    .dec         (dec),
    .id_valid    (id_valid),  // Gates forwarding from the instr in execute
    .ex_rd       (ex_rd),
    .ex_wr       (ex_wr),
    .wb_rd       (wb_rd),
    .wb_wr       (wb_wr),
    .id_rd       (id_rd),
    .id_use_rf_a (id_use_rf_a),
    .id_use_rf_b (id_use_rf_b),
    .id_byp_ex_a (id_byp_ex_a),
    .id_byp_ex_b (id_byp_ex_b),
    .id_byp_wb_a (id_byp_wb_a),
    .id_byp_wb_b (id_byp_wb_b)
  );

  operand_select u_operands (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_pc    (in_pc),
    .hold     (hold),
    .flush    (flush),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dec      (dec),
    .id_valid (id_valid),
    .id_pc    (id_pc),
    .id_op_a  (id_op_a),
    .id_op_b  (id_op_b),
    .id_imm   (id_imm)
  );

endmodule

`default_nettype wire

// ==== verif/tb_id_stage.sv ====
`default_nettype none

`include "id_settings.svh"

module tb_id_stage import id_pkg::*; ();

  logic      clk;
  logic      rst_n;
  logic      in_valid;
  instr_t    in_instr;
  xlen_t     in_pc;
  logic      hold;
  logic      flush;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  reg_addr_t ex_rd;
  logic      ex_wr;
  reg_addr_t wb_rd;
  logic      wb_wr;
  logic      id_valid;
  xlen_t     id_pc;
  xlen_t     id_op_a;
  xlen_t     id_op_b;
  xlen_t     id_imm;
  reg_addr_t id_rd;
  logic      id_illegal;
  logic      id_use_rf_a;
  logic      id_use_rf_b;
  logic      id_byp_ex_a;
  logic      id_byp_ex_b;
  logic      id_byp_wb_a;
  logic      id_byp_wb_b;

  // Model predictions for the instruction in flight
  xlen_t     exp_pc;
  xlen_t     exp_op_a;
  xlen_t     exp_op_b;
  xlen_t     exp_imm;
  reg_addr_t exp_rd;

  logic [31:0] seed = 32'hdb88;
  int          checks = 0;
  int          errors = 0;

  id_stage i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #5000;
    $display("Watchdog expired before the testbench finished");
    $display("Something failed");
    $finish;
  end

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  //////////////////////////////////////////////////
  // Instruction encoders
  //////////////////////////////////////////////////
  function automatic instr_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic instr_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic instr_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                    input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic instr_t j_type(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic wait_edges(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
    end
    #1;  // Stimulus and sampling point
  endtask

  // Drives one instruction and predicts its execute view
  task automatic present_instr(input instr_t instr, input xlen_t pc, input xlen_t imm);
    in_valid  = 1'b1;
    in_instr  = instr;
    in_pc     = pc;
    rs1_data  = next_random();
    rs2_data  = next_random();
    exp_pc    = pc;
    exp_imm   = imm;
    exp_rd    = instr[11:7];
    case (opcode_e'(instr[6:2]))
      OPC_AUIPC, OPC_JAL: exp_op_a = pc;
      OPC_LUI:            exp_op_a = '0;
      default:            exp_op_a = rs1_data;
    endcase
    case (opcode_e'(instr[6:2]))
      OPC_OP, OPC_BRANCH, OPC_STORE: exp_op_b = rs2_data;
      OPC_SYSTEM:                    exp_op_b = xlen_t'(instr[19:15]);  // CSR zimm
      default:                       exp_op_b = imm;
    endcase
  endtask

  task automatic expect_outputs();
    check_bit("id_valid", id_valid, 1'b1);
    check_word("id_pc", id_pc, exp_pc);
    check_word("id_op_a", id_op_a, exp_op_a);
    check_word("id_op_b", id_op_b, exp_op_b);
    check_word("id_imm", id_imm, exp_imm);
    check_addr("id_rd", id_rd, exp_rd);
  endtask

  task automatic expect_flags(input logic rf_a, input logic rf_b, input logic ex_a,
                              input logic ex_b, input logic wb_a, input logic wb_b);
    check_bit("id_use_rf_a", id_use_rf_a, rf_a);
    check_bit("id_use_rf_b", id_use_rf_b, rf_b);
    check_bit("id_byp_ex_a", id_byp_ex_a, ex_a);
    check_bit("id_byp_ex_b", id_byp_ex_b, ex_b);
    check_bit("id_byp_wb_a", id_byp_wb_a, wb_a);
    check_bit("id_byp_wb_b", id_byp_wb_b, wb_b);
  endtask

  // Bubble cycle, later stages quiet
  task automatic idle_cycle();
    in_valid = 1'b0;
    ex_wr    = 1'b0;
    wb_wr    = 1'b0;
    hold     = 1'b0;
    flush    = 1'b0;
    wait_edges(1);
    check_bit("id_valid", id_valid, 1'b0);
  endtask

  task automatic run_one(input instr_t instr, input xlen_t pc, input xlen_t imm);
    present_instr(instr, pc, imm);
    #1;
    check_addr("rs1_addr", rs1_addr, instr[19:15]);
    check_addr("rs2_addr", rs2_addr, instr[24:20]);
    wait_edges(1);
    expect_outputs();
  endtask

  task automatic judge_legality(input instr_t instr, input logic exp_illegal);
    in_valid = 1'b1;
    in_instr = instr;
    wait_edges(1);
    check_bit("id_illegal", id_illegal, exp_illegal);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic operands_and_immediates();
    run_one(i_type(12'hffd, 5'd1, 3'b000, 5'd5, 7'h13), 32'h1000, 32'hffff_fffd);  // ADDI
    run_one(s_type(12'hff8, 5'd7, 5'd2, 3'b010), 32'h1004, 32'hffff_fff8);         // SW
    run_one(b_type(13'h1fe0, 5'd4, 5'd3, 3'b000), 32'h1008, 32'hffff_ffe0);        // BEQ
    run_one(u_type(20'habcde, 5'd8, 7'h37), 32'h100c, 32'habcd_e000);              // LUI
    run_one(u_type(20'h12345, 5'd9, 7'h17), 32'h1010, 32'h1234_5000);              // AUIPC
    run_one(j_type(21'h1ab2c6, 5'd1), 32'h1014, 32'hfffa_b2c6);                    // JAL
    run_one(i_type(12'h305, 5'h15, 3'b101, 5'd10, 7'h73), 32'h1018, 32'h305);      // CSRRWI
  endtask

  task automatic legality_table();
    judge_legality(i_type(12'h0ff, 5'd0, 3'b000, 5'd0, 7'h0f), 1'b0);  // FENCE
    judge_legality(32'h0000_0073, 1'b0);                                // ECALL
    for (int f = 0; f < 8; f++) begin
      judge_legality(r_type(7'h01, 5'd3, 5'd2, 3'(f), 5'd1, 7'h33), (`HAS_MULDIV == 0));
    end
    judge_legality(i_type(12'h000, 5'd1, 3'b000, 5'd2, 7'h0b), 1'b1);   // No such opcode
    judge_legality(i_type({7'h01, 5'd3}, 5'd1, 3'b001, 5'd2, 7'h13), 1'b1);
    judge_legality(i_type(12'h300, 5'd1, 3'b100, 5'd2, 7'h73), 1'b1);
  endtask

  task automatic back_to_back_forwarding();
    idle_cycle();
    present_instr(i_type(12'h001, 5'd1, 3'b000, 5'd5, 7'h13), 32'h200, 32'h1);
    wait_edges(1);
    present_instr(r_type(7'h00, 5'd5, 5'd5, 3'b000, 5'd6, 7'h33), 32'h204, 32'h0);
    wait_edges(1);
    expect_flags(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
    // Producer targets x0
    present_instr(i_type(12'h001, 5'd1, 3'b000, 5'd0, 7'h13), 32'h208, 32'h1);
    wait_edges(1);
    present_instr(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd6, 7'h33), 32'h20c, 32'h0);
    wait_edges(1);
    expect_flags(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic later_stage_forwarding();
    idle_cycle();
    ex_rd = 5'd7;
    ex_wr = 1'b1;
    wb_rd = 5'd8;
    wb_wr = 1'b1;
    present_instr(r_type(7'h00, 5'd8, 5'd7, 3'b000, 5'd9, 7'h33), 32'h300, 32'h0);
    wait_edges(1);
    expect_flags(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    present_instr(r_type(7'h00, 5'd7, 5'd8, 3'b000, 5'd9, 7'h33), 32'h304, 32'h0);
    wait_edges(1);
    expect_flags(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
    ex_wr = 1'b0;  // Same matches, no writes
    wb_wr = 1'b0;
    present_instr(r_type(7'h00, 5'd8, 5'd7, 3'b000, 5'd9, 7'h33), 32'h308, 32'h0);
    wait_edges(1);
    expect_flags(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic hold_and_flush();
    idle_cycle();
    present_instr(i_type(12'hffd, 5'd1, 3'b000, 5'd5, 7'h13), 32'h400, 32'hffff_fffd);
    wait_edges(1);
    expect_outputs();
    expect_flags(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    hold  = 1'b1;
    ex_rd = 5'd5;  // Would forward if not held
    ex_wr = 1'b1;
    wb_rd = 5'd5;
    wb_wr = 1'b1;
    for (int i = 0; i < 3; i++) begin
      // Illegal OP reading x5, the held destination
      in_instr = r_type(7'h02, 5'd5, 5'd5, 3'b000, 5'(i + 10), 7'h33);
      in_pc    = next_random();
      rs1_data = next_random();
      rs2_data = next_random();
      wait_edges(1);
      expect_outputs();
      expect_flags(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      check_bit("id_illegal", id_illegal, 1'b0);
    end
    flush = 1'b1;
    wait_edges(1);
    check_bit("id_valid", id_valid, 1'b0);
    idle_cycle();
  endtask

  initial begin
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_instr = '0;
    in_pc    = '0;
    hold     = 1'b0;
    flush    = 1'b0;
    rs1_data = '0;
    rs2_data = '0;
    ex_rd    = '0;
    ex_wr    = 1'b0;
    wb_rd    = '0;
    wb_wr    = 1'b0;
    wait_edges(5);
    check_bit("id_valid", id_valid, 1'b0);
    check_bit("id_illegal", id_illegal, 1'b0);
    expect_flags(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    rst_n = 1'b1;
    wait_edges(1);

    operands_and_immediates();
    legality_table();
    back_to_back_forwarding();
    later_stage_forwarding();
    hold_and_flush();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hw
hw/id_pkg.sv
hw/dec_if.sv
hw/instr_decoder.sv
hw/illegal_check.sv
hw/bypass_ctrl.sv
hw/operand_select.sv
hw/id_stage.sv
verif/tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_id_stage -o tb_id_stage

out=$(./obj_dir/tb_id_stage)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
